/* rtl/sa_ctrl_pkg.sv */
package sa_ctrl_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Pass states
    ///////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_WAIT_WEIGHT,
        ST_LOAD,
        ST_WAIT_BRAM,
        ST_READY,
        ST_STREAM,
        ST_DRAIN,
        ST_STORE,
        ST_NEXT
    } sa_state_e;

    ///////////////////////////////////////////////////////////////////////
    // Phase timing
    ///////////////////////////////////////////////////////////////////////

    // Array settle time between weight load and streaming
    localparam int READY_CYCLES = 3;

    // Drain is 2 cycles per extra filter tap on top of this
    localparam int DRAIN_BASE_CYCLES = 6;

endpackage

/* rtl/sa_pass_fsm.sv */
`timescale 1ns/100ps

module sa_pass_fsm #(
    parameter int N_COLS          = 4,
    parameter int MAX_FILTER_SIZE = 3,
    parameter int ADDR_W          = 16,
    parameter int CNT_W           = 8,
    localparam int COL_W          = $clog2(MAX_FILTER_SIZE + 1)
) (
    input  logic                   clk_i,
    input  logic                   sel_mux_tr_rst,
    input  logic                   layer_start_i,
    input  logic                   input_ready_i,
    input  logic                   weight_ready_i,
    input  logic                   bram_ready_i,
    input  logic                   channels_done_i,
    input  logic                   last_filter_i,
    input  logic                   last_input_i,
    input  logic [COL_W-1:0]       filter_size_i,
    input  logic [CNT_W-1:0]       inputs_per_round_i,
    output sa_ctrl_pkg::sa_state_e state_o,
    output logic                   layer_start_o,
    output logic                   rst_o,
    output logic                   load_o,
    output logic                   ready_o,
    output logic                   start_op_o,
    output logic                   rd_weight_ld_o,
    output logic                   rd_feature_ld_o,
    output logic                   rd_rom_signals_ld_o,
    output logic                   done_o,
    output logic [ADDR_W-1:0]      in_feature_addr_o,
    output logic [ADDR_W-1:0]      addrs_rom_signal_o
);

    sa_ctrl_pkg::sa_state_e state_q, state_d;
    logic [CNT_W-1:0]       step_q;
    logic [CNT_W-1:0]       step_limit;
    logic [CNT_W-1:0]       drain_len;
    logic                   step_last;
    logic                   layer_done;

    // 2*(fs-1) + base
    assign drain_len = CNT_W'(2 * (int'(filter_size_i) - 1) + sa_ctrl_pkg::DRAIN_BASE_CYCLES);

    always_comb begin
        case (state_q)
            sa_ctrl_pkg::ST_LOAD:   step_limit = CNT_W'(N_COLS);
            sa_ctrl_pkg::ST_READY:  step_limit = CNT_W'(sa_ctrl_pkg::READY_CYCLES);
            sa_ctrl_pkg::ST_STREAM: step_limit = inputs_per_round_i;
            default:                step_limit = drain_len;
        endcase
    end

    assign step_last  = (step_q == step_limit - 1'b1);
    assign layer_done = last_filter_i && last_input_i;

    ///////////////////////////////////////////////////////////////////////
    // Next state
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            sa_ctrl_pkg::ST_IDLE, sa_ctrl_pkg::ST_NEXT: begin
                // Idle waits for a start, NEXT for the next input block
                if ((state_q == sa_ctrl_pkg::ST_IDLE) ? layer_start_i : input_ready_i) begin
                    state_d = weight_ready_i ? sa_ctrl_pkg::ST_LOAD
                                             : sa_ctrl_pkg::ST_WAIT_WEIGHT;
                end
            end
            sa_ctrl_pkg::ST_WAIT_WEIGHT:
                if (weight_ready_i) state_d = sa_ctrl_pkg::ST_LOAD;
            sa_ctrl_pkg::ST_LOAD:
                if (step_last) state_d = sa_ctrl_pkg::ST_WAIT_BRAM;
            sa_ctrl_pkg::ST_WAIT_BRAM:
                if (bram_ready_i) state_d = sa_ctrl_pkg::ST_READY;
            sa_ctrl_pkg::ST_READY:
                if (step_last) state_d = sa_ctrl_pkg::ST_STREAM;
            sa_ctrl_pkg::ST_STREAM:
                if (step_last) state_d = sa_ctrl_pkg::ST_DRAIN;
            sa_ctrl_pkg::ST_DRAIN:
                if (step_last) begin
                    state_d = channels_done_i ? sa_ctrl_pkg::ST_STORE : sa_ctrl_pkg::ST_NEXT;
                end
            sa_ctrl_pkg::ST_STORE:
                state_d = layer_done ? sa_ctrl_pkg::ST_IDLE : sa_ctrl_pkg::ST_NEXT;
            default:
                state_d = sa_ctrl_pkg::ST_IDLE;
        endcase
    end

    // Step counter restarts on every state change
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            state_q <= sa_ctrl_pkg::ST_IDLE;
            step_q  <= '0;
        end else begin
            state_q <= state_d;
            step_q  <= (state_d != state_q) ? '0 : step_q + 1'b1;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Address counters
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            in_feature_addr_o  <= '0;
            addrs_rom_signal_o <= '0;
        end else begin
            if (state_q == sa_ctrl_pkg::ST_LOAD) begin
                in_feature_addr_o <= '0;
            end else if (state_q == sa_ctrl_pkg::ST_STREAM) begin
                in_feature_addr_o <= in_feature_addr_o + 1'b1;
            end
            // ROM address runs on across passes of one layer
            if (layer_start_o) begin
                addrs_rom_signal_o <= '0;
            end else if (state_q == sa_ctrl_pkg::ST_LOAD) begin
                addrs_rom_signal_o <= addrs_rom_signal_o + 1'b1;
            end
        end
    end

    assign state_o             = state_q;
    assign layer_start_o       = (state_q == sa_ctrl_pkg::ST_IDLE) && layer_start_i;
    assign rst_o               = (state_q == sa_ctrl_pkg::ST_IDLE);
    assign load_o              = (state_q == sa_ctrl_pkg::ST_LOAD);
    assign rd_weight_ld_o      = load_o;
    assign rd_rom_signals_ld_o = load_o;
    assign ready_o             = (state_q == sa_ctrl_pkg::ST_READY);
    assign rd_feature_ld_o     = (state_q == sa_ctrl_pkg::ST_STREAM);
    assign start_op_o          = rd_feature_ld_o || (state_q == sa_ctrl_pkg::ST_DRAIN);
    assign done_o              = (state_q == sa_ctrl_pkg::ST_STORE) && layer_done;

    // Weights must be settled before the array computes
    a_load_op_excl: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        !(load_o && start_op_o));

    a_state_legal: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        state_q <= sa_ctrl_pkg::ST_NEXT);

endmodule

/* rtl/sa_round_tracker.sv */
`timescale 1ns/100ps

module sa_round_tracker #(
    parameter int N_ROWS          = 4,
    parameter int MAX_FILTER_SIZE = 3,
    parameter int CNT_W           = 8,
    localparam int COL_W          = $clog2(MAX_FILTER_SIZE + 1)
) (
    input  logic                   clk_i,
    input  logic                   sel_mux_tr_rst,
    input  logic                   layer_start_i,
    input  sa_ctrl_pkg::sa_state_e state_i,
    input  logic [COL_W-1:0]       filter_size_i,
    input  logic [CNT_W-1:0]       total_channels_i,
    input  logic [CNT_W-1:0]       filter_rounds_i,
    input  logic [CNT_W-1:0]       input_rounds_i,
    input  logic [CNT_W-1:0]       inputs_per_round_i,
    output logic [COL_W-1:0]       filter_size_o,
    output logic [CNT_W-1:0]       inputs_per_round_o,
    output logic                   channels_done_o,
    output logic                   last_filter_o,
    output logic                   last_input_o
);

    logic [CNT_W-1:0] total_channels_q;
    logic [CNT_W-1:0] filter_rounds_q;
    logic [CNT_W-1:0] input_rounds_q;
    logic [CNT_W-1:0] ch_step_q;
    logic [CNT_W-1:0] ch_cnt_q;
    logic [CNT_W-1:0] filter_cnt_q;
    logic [CNT_W-1:0] input_cnt_q;
    logic             in_drain_q;
    logic             drain_entry;
    logic             in_store;

    assign drain_entry = (state_i == sa_ctrl_pkg::ST_DRAIN) && !in_drain_q;
    assign in_store    = (state_i == sa_ctrl_pkg::ST_STORE);

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            filter_size_o      <= '0;
            inputs_per_round_o <= '0;
            total_channels_q   <= '0;
            filter_rounds_q    <= '0;
            input_rounds_q     <= '0;
            ch_step_q          <= '0;
            ch_cnt_q           <= '0;
            filter_cnt_q       <= '0;
            input_cnt_q        <= '0;
            in_drain_q         <= 1'b0;
        end else begin
            in_drain_q <= (state_i == sa_ctrl_pkg::ST_DRAIN);
            if (layer_start_i) begin
                filter_size_o      <= filter_size_i;
                inputs_per_round_o <= inputs_per_round_i;
                total_channels_q   <= total_channels_i;
                filter_rounds_q    <= filter_rounds_i;
                input_rounds_q     <= input_rounds_i;
                // Channels covered by one pass of the array
                ch_step_q          <= CNT_W'(N_ROWS / filter_size_i);
                ch_cnt_q           <= '0;
                filter_cnt_q       <= '0;
                input_cnt_q        <= '0;
            end else if (drain_entry) begin
                ch_cnt_q <= ch_cnt_q + ch_step_q;
            end else if (in_store) begin
                ch_cnt_q <= '0;
                if (last_filter_o) begin
                    filter_cnt_q <= '0;
                    input_cnt_q  <= input_cnt_q + 1'b1;
                end else begin
                    filter_cnt_q <= filter_cnt_q + 1'b1;
                end
            end
        end
    end

    assign channels_done_o = (ch_cnt_q >= total_channels_q);
    assign last_filter_o   = (filter_cnt_q == filter_rounds_q - 1'b1);
    assign last_input_o    = (input_cnt_q == input_rounds_q - 1'b1);

    // Channel step divides by this
    a_fs_nonzero: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        (state_i != sa_ctrl_pkg::ST_IDLE) |-> (filter_size_o != '0));

endmodule

/* rtl/sa_row_ctrl_decode.sv */
`timescale 1ns/100ps

module sa_row_ctrl_decode #(
    parameter int N_ROWS           = 4,
    parameter int MAX_FILTER_SIZE  = 3,
    parameter int MAX_LEN_TRANSFER = 4,
    localparam int SEL_W           = $clog2(MAX_FILTER_SIZE),
    localparam int COL_W           = $clog2(MAX_FILTER_SIZE + 1),
    localparam int TR_W            = $clog2(MAX_LEN_TRANSFER),
    localparam int ROM_W           = N_ROWS * (SEL_W + COL_W + TR_W + 1)
) (
    input  logic                              clk_i,
    input  logic                              sel_mux_tr_rst,
    input  logic                              clear_i,
    input  logic                              load_i,
    input  logic [ROM_W-1:0]                  rom_word_i,
    input  logic [COL_W-1:0]                  filter_size_i,
    output logic [N_ROWS-1:0][SEL_W-1:0]      f_sel_o,
    output logic [N_ROWS-1:0][COL_W-1:0]      number_of_columns_o,
    output logic [N_ROWS-1:0][COL_W-1:0]      column_num_o,
    output logic [N_ROWS-1:0][TR_W-1:0]       sel_mux_tr_o,
    output logic [N_ROWS-1:0]                 en_adder_node_o,
    output logic [N_ROWS-1:0][COL_W-1:0]      row_num_o,
    output logic [N_ROWS-1:0]                 sel_mux_node_o
);

    // Field offsets inside the ROM word
    localparam int COL_OFS = N_ROWS * SEL_W;
    localparam int TR_OFS  = COL_OFS + N_ROWS * COL_W;
    localparam int EN_OFS  = TR_OFS + N_ROWS * TR_W;

    logic [N_ROWS-1:0][SEL_W-1:0] rom_f_sel;
    logic [N_ROWS-1:0][COL_W-1:0] rom_ncols;
    logic [N_ROWS-1:0][TR_W-1:0]  rom_tr;
    logic [N_ROWS-1:0][TR_W-1:0]  tr_pre_q;
    logic [N_ROWS-1:0][COL_W-1:0] col_cnt_q;

    for (genvar r = 0; r < N_ROWS; r++) begin : g_slice
        assign rom_f_sel[r] = rom_word_i[r*SEL_W +: SEL_W];
        assign rom_ncols[r] = rom_word_i[COL_OFS + r*COL_W +: COL_W];
        assign rom_tr[r]    = rom_word_i[TR_OFS + r*TR_W +: TR_W];
    end

    ///////////////////////////////////////////////////////////////////////
    // Registered row controls
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            f_sel_o             <= '0;
            number_of_columns_o <= '0;
            column_num_o        <= '0;
            en_adder_node_o     <= '0;
            tr_pre_q            <= '0;
            sel_mux_tr_o        <= '0;
            col_cnt_q           <= '0;
        end else if (clear_i) begin
            f_sel_o             <= '0;
            number_of_columns_o <= '0;
            column_num_o        <= '0;
            en_adder_node_o     <= '0;
            tr_pre_q            <= '0;
            sel_mux_tr_o        <= '0;
            col_cnt_q           <= '0;
        end else if (load_i) begin
            f_sel_o             <= rom_f_sel;
            number_of_columns_o <= rom_ncols;
            en_adder_node_o     <= rom_word_i[EN_OFS +: N_ROWS];
            // Transfer select lags the load by two beats
            tr_pre_q            <= rom_tr;
            sel_mux_tr_o        <= tr_pre_q;
            for (int r = 0; r < N_ROWS; r++) begin
                column_num_o[r] <= rom_ncols[r] - col_cnt_q[r];
                if (col_cnt_q[r] == rom_ncols[r] - 1'b1) begin
                    col_cnt_q[r] <= '0;
                end else begin
                    col_cnt_q[r] <= col_cnt_q[r] + 1'b1;
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Row map repeating 1..filter_size down the array
    ///////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [COL_W-1:0] num;
        num = COL_W'(1);
        for (int r = 0; r < N_ROWS; r++) begin
            row_num_o[r] = num;
            // Last row of each filter group feeds the node adder directly
            sel_mux_node_o[r] = (num != filter_size_i);
            num = (num == filter_size_i) ? COL_W'(1) : num + 1'b1;
        end
    end

endmodule

/* rtl/sa_ctrl_top.sv */
`timescale 1ns/100ps

module sa_ctrl_top #(
    parameter int N_ROWS           = 4,
    parameter int N_COLS           = 4,
    parameter int MAX_FILTER_SIZE  = 3,
    parameter int MAX_LEN_TRANSFER = 4,
    parameter int ADDR_W           = 16,
    parameter int CNT_W            = 8,
    localparam int SEL_W           = $clog2(MAX_FILTER_SIZE),
    localparam int COL_W           = $clog2(MAX_FILTER_SIZE + 1),
    localparam int TR_W            = $clog2(MAX_LEN_TRANSFER),
    localparam int ROM_W           = N_ROWS * (SEL_W + COL_W + TR_W + 1)
) (
    input  logic                         clk_i,
    input  logic                         sel_mux_tr_rst,
    input  logic                         layer_start_i,
    input  logic [COL_W-1:0]             filter_size_i,
    input  logic [CNT_W-1:0]             total_channels_i,
    input  logic [CNT_W-1:0]             filter_rounds_i,
    input  logic [CNT_W-1:0]             input_rounds_i,
    input  logic [CNT_W-1:0]             inputs_per_round_i,
    input  logic                         input_ready_i,
    input  logic                         weight_ready_i,
    input  logic                         bram_ready_i,
    input  logic [ROM_W-1:0]             rom_word_i,
    output logic                         rst_o,
    output logic                         load_o,
    output logic                         ready_o,
    output logic                         start_op_o,
    output logic                         rd_weight_ld_o,
    output logic                         rd_feature_ld_o,
    output logic                         rd_rom_signals_ld_o,
    output logic                         done_o,
    output logic [ADDR_W-1:0]            in_feature_addr_o,
    output logic [ADDR_W-1:0]            addrs_rom_signal_o,
    output logic [N_ROWS-1:0][SEL_W-1:0] f_sel_o,
    output logic [N_ROWS-1:0][COL_W-1:0] number_of_columns_o,
    output logic [N_ROWS-1:0][COL_W-1:0] column_num_o,
    output logic [N_ROWS-1:0][TR_W-1:0]  sel_mux_tr_o,
    output logic [N_ROWS-1:0]            en_adder_node_o,
    output logic [N_ROWS-1:0][COL_W-1:0] row_num_o,
    output logic [N_ROWS-1:0]            sel_mux_node_o
);

    sa_ctrl_pkg::sa_state_e state;
    logic                   layer_start;
    logic                   channels_done;
    logic                   last_filter;
    logic                   last_input;
    logic [COL_W-1:0]       filter_size;
    logic [CNT_W-1:0]       inputs_per_round;

    sa_pass_fsm #(
        .N_COLS(N_COLS), .MAX_FILTER_SIZE(MAX_FILTER_SIZE), .ADDR_W(ADDR_W), .CNT_W(CNT_W)
    ) i_pass_fsm (
        .clk_i, .sel_mux_tr_rst, .layer_start_i, .input_ready_i, .weight_ready_i,
        .bram_ready_i,
        .channels_done_i(channels_done), .last_filter_i(last_filter),
        .last_input_i(last_input), .filter_size_i(filter_size),
        .inputs_per_round_i(inputs_per_round),
        .state_o(state), .layer_start_o(layer_start),
        .rst_o, .load_o, .ready_o, .start_op_o, .rd_weight_ld_o, .rd_feature_ld_o,
        .rd_rom_signals_ld_o, .done_o, .in_feature_addr_o, .addrs_rom_signal_o
    );

    sa_round_tracker #(
        .N_ROWS(N_ROWS), .MAX_FILTER_SIZE(MAX_FILTER_SIZE), .CNT_W(CNT_W)
    ) i_round_tracker (
        .clk_i, .sel_mux_tr_rst, .layer_start_i(layer_start), .state_i(state),
        .filter_size_i, .total_channels_i, .filter_rounds_i, .input_rounds_i,
        .inputs_per_round_i,
        .filter_size_o(filter_size), .inputs_per_round_o(inputs_per_round),
        .channels_done_o(channels_done), .last_filter_o(last_filter),
        .last_input_o(last_input)
    );

    sa_row_ctrl_decode #(
        .N_ROWS(N_ROWS), .MAX_FILTER_SIZE(MAX_FILTER_SIZE), .MAX_LEN_TRANSFER(MAX_LEN_TRANSFER)
    ) i_row_ctrl_decode (
        .clk_i, .sel_mux_tr_rst, .clear_i(rst_o), .load_i(load_o), .rom_word_i,
        .filter_size_i(filter_size),
        .f_sel_o, .number_of_columns_o, .column_num_o, .sel_mux_tr_o, .en_adder_node_o,
        .row_num_o, .sel_mux_node_o
    );

endmodule

/* bench/sa_ctrl_tb.sv */
`timescale 1ns/100ps

module sa_ctrl_tb;

    localparam int N_ROWS     = 4;
    localparam int N_COLS     = 4;
    localparam int CNT_W      = 8;
    localparam int SEL_W      = $clog2(3);
    localparam int COL_W      = $clog2(3 + 1);
    localparam int TR_W       = $clog2(4);
    localparam int ROM_W      = N_ROWS * (SEL_W + COL_W + TR_W + 1);
    localparam int COL_MASK   = (1 << COL_W) - 1;
    localparam int READY_LEN  = 3;
    localparam int DRAIN_BASE = 6;
    localparam int N_CASES    = 5;

    logic                         clk_i;
    logic                         sel_mux_tr_rst;
    logic                         layer_start_i;
    logic [COL_W-1:0]             filter_size_i;
    logic [CNT_W-1:0]             total_channels_i;
    logic [CNT_W-1:0]             filter_rounds_i;
    logic [CNT_W-1:0]             input_rounds_i;
    logic [CNT_W-1:0]             inputs_per_round_i;
    logic                         input_ready_i;
    logic                         weight_ready_i;
    logic                         bram_ready_i;
    logic [ROM_W-1:0]             rom_word_i;
    logic                         rst_o;
    logic                         load_o;
    logic                         ready_o;
    logic                         start_op_o;
    logic                         rd_weight_ld_o;
    logic                         rd_feature_ld_o;
    logic                         rd_rom_signals_ld_o;
    logic                         done_o;
    logic [15:0]                  in_feature_addr_o;
    logic [15:0]                  addrs_rom_signal_o;
    logic [N_ROWS-1:0][SEL_W-1:0] f_sel_o;
    logic [N_ROWS-1:0][COL_W-1:0] number_of_columns_o;
    logic [N_ROWS-1:0][COL_W-1:0] column_num_o;
    logic [N_ROWS-1:0][TR_W-1:0]  sel_mux_tr_o;
    logic [N_ROWS-1:0]            en_adder_node_o;
    logic [N_ROWS-1:0][COL_W-1:0] row_num_o;
    logic [N_ROWS-1:0]            sel_mux_node_o;

    // Layer table of filter size, channels, filter and input rounds, inputs and ROM seed
    int          fs_tab   [N_CASES] = '{1, 2, 2, 1, 2};
    int          ch_tab   [N_CASES] = '{3, 5, 2, 9, 1};
    int          fr_tab   [N_CASES] = '{1, 2, 1, 2, 3};
    int          ir_tab   [N_CASES] = '{2, 1, 3, 1, 1};
    int          ipr_tab  [N_CASES] = '{5, 3, 1, 7, 2};
    logic [31:0] seed_tab [N_CASES] = '{32'h0000_0011, 32'h0bad_f00d, 32'h1234_5678,
                                        32'h00ff_00ff, 32'h7777_0001};

    // Row control model as of the latest clock edge
    int exp_fsel [N_ROWS];
    int exp_ncols [N_ROWS];
    int exp_colnum [N_ROWS];
    int exp_tr_pre [N_ROWS];
    int exp_tr [N_ROWS];
    int exp_en [N_ROWS];
    int col_cnt [N_ROWS];

    logic [31:0] ready_rng = 32'h5da9_ba21;
    logic [31:0] case_seed = 32'h0;
    logic        hold_weight = 1'b1;
    int          cur_case = 0;
    int          pass_cnt = 0;
    int          done_cnt = 0;
    int          load_run = 0;
    int          ready_run = 0;
    int          op_run = 0;
    int          feat_idx = 0;
    logic        prev_load = 1'b0;
    logic        prev_ready = 1'b0;
    logic        prev_op = 1'b0;
    logic        prev_feat = 1'b0;
    int          cycle_cnt = 0;
    int          timeout_limit = 0;

    sa_ctrl_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    ///////////////////////////////////////////////////////////////////////
    // Reference rules
    ///////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic int expected_passes(input int c);
        int per_pass;
        per_pass = N_ROWS / fs_tab[c];
        return ((ch_tab[c] + per_pass - 1) / per_pass) * fr_tab[c] * ir_tab[c];
    endfunction

    function automatic int drain_cycles(input int fs);
        return 2 * (fs - 1) + DRAIN_BASE;
    endfunction

    function automatic int field(input logic [ROM_W-1:0] word, input int lsb, input int width);
        return int'((word >> lsb) & ((ROM_W'(1) << width) - 1'b1));
    endfunction

    function automatic int timeout_cycles();
        int sum;
        sum = 100;
        for (int c = 0; c < N_CASES; c++) begin
            sum += expected_passes(c) * (N_COLS + READY_LEN + ipr_tab[c]
                                         + drain_cycles(fs_tab[c]) + 40);
        end
        return sum;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Checking
    ///////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_value(input string what, input int exp, input int act);
        assert (exp == act) else begin
            $display("[ERROR] case %0d %s: expected %0d, actual %0d", cur_case, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_rows();
        int grp;
        for (int r = 0; r < N_ROWS; r++) begin
            check_value($sformatf("f_sel_o[%0d]", r), exp_fsel[r], f_sel_o[r]);
            check_value($sformatf("number_of_columns_o[%0d]", r), exp_ncols[r],
                        number_of_columns_o[r]);
            check_value($sformatf("column_num_o[%0d]", r), exp_colnum[r], column_num_o[r]);
            check_value($sformatf("sel_mux_tr_o[%0d]", r), exp_tr[r], sel_mux_tr_o[r]);
            check_value($sformatf("en_adder_node_o[%0d]", r), exp_en[r], en_adder_node_o[r]);
            // Row map only means something once a layer is latched
            if (!rst_o) begin
                grp = r % fs_tab[cur_case] + 1;
                check_value($sformatf("row_num_o[%0d]", r), grp, row_num_o[r]);
                check_value($sformatf("sel_mux_node_o[%0d]", r),
                            int'(grp != fs_tab[cur_case]), sel_mux_node_o[r]);
            end
        end
    endtask

    task automatic step_row_model();
        int ncols;
        for (int r = 0; r < N_ROWS; r++) begin
            if (sel_mux_tr_rst || rst_o) begin
                exp_fsel[r]   = 0;
                exp_ncols[r]  = 0;
                exp_colnum[r] = 0;
                exp_tr_pre[r] = 0;
                exp_tr[r]     = 0;
                exp_en[r]     = 0;
                col_cnt[r]    = 0;
            end else if (load_o) begin
                ncols         = field(rom_word_i, N_ROWS * SEL_W + r * COL_W, COL_W);
                exp_fsel[r]   = field(rom_word_i, r * SEL_W, SEL_W);
                exp_ncols[r]  = ncols;
                exp_colnum[r] = (ncols - col_cnt[r]) & COL_MASK;
                col_cnt[r]    = (col_cnt[r] == ((ncols - 1) & COL_MASK)) ? 0
                                : (col_cnt[r] + 1) & COL_MASK;
                // Two-load lag on the transfer select
                exp_tr[r]     = exp_tr_pre[r];
                exp_tr_pre[r] = field(rom_word_i, N_ROWS * (SEL_W + COL_W) + r * TR_W, TR_W);
                exp_en[r]     = field(rom_word_i, N_ROWS * (SEL_W + COL_W + TR_W) + r, 1);
            end
        end
    endtask

    task automatic track_phases();
        check_value("rd_weight_ld_o", load_o, rd_weight_ld_o);
        check_value("rd_rom_signals_ld_o", load_o, rd_rom_signals_ld_o);
        if (load_o) begin
            pass_cnt += int'(!prev_load);
            load_run++;
        end else if (prev_load) begin
            check_value("load length", N_COLS, load_run);
            load_run = 0;
        end
        if (ready_o) begin
            ready_run++;
        end else if (prev_ready) begin
            check_value("ready length", READY_LEN, ready_run);
            ready_run = 0;
        end
        if (start_op_o) begin
            op_run++;
        end else if (prev_op) begin
            check_value("stream plus drain length",
                        ipr_tab[cur_case] + drain_cycles(fs_tab[cur_case]), op_run);
            op_run = 0;
        end
        if (rd_feature_ld_o) begin
            check_value("in_feature_addr_o", feat_idx, in_feature_addr_o);
            feat_idx++;
        end else if (prev_feat) begin
            check_value("feature beats", ipr_tab[cur_case], feat_idx);
            feat_idx = 0;
        end
        if (done_o) begin
            done_cnt++;
            check_value("pass count", expected_passes(cur_case), pass_cnt);
            check_value("ROM address at done", expected_passes(cur_case) * N_COLS,
                        addrs_rom_signal_o);
        end
        prev_load  = load_o;
        prev_ready = ready_o;
        prev_op    = start_op_o;
        prev_feat  = rd_feature_ld_o;
    endtask

    // Outputs are sampled half a cycle away from the driving edge
    always @(negedge clk_i) begin
        if (!sel_mux_tr_rst) begin
            check_rows();
            track_phases();
        end
        step_row_model();
    end

    // Ready levels and ROM words
    always @(posedge clk_i) begin
        ready_rng = xorshift32(ready_rng);
        weight_ready_i <= hold_weight ? 1'b0 : ready_rng[3];
        bram_ready_i   <= ready_rng[11];
        input_ready_i  <= ready_rng[19];
        rom_word_i     <= ROM_W'(xorshift32(ready_rng ^ case_seed));
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            $display("Timeout: layer %0d not done after %0d cycles, FSM in %s",
                     cur_case, cycle_cnt, i_dut.state.name());
            stop_run();
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Layer sequence
    ///////////////////////////////////////////////////////////////////////

    initial begin
        sel_mux_tr_rst     = 1'b1;
        layer_start_i      = 1'b0;
        filter_size_i      = '0;
        total_channels_i   = '0;
        filter_rounds_i    = '0;
        input_rounds_i     = '0;
        inputs_per_round_i = '0;
        input_ready_i      = 1'b0;
        weight_ready_i     = 1'b0;
        bram_ready_i       = 1'b0;
        rom_word_i         = '0;
        timeout_limit      = timeout_cycles();
        repeat (3) @(posedge clk_i);
        sel_mux_tr_rst <= 1'b0;
        repeat (4) begin
            @(negedge clk_i);
            check_value("idle rst_o", 1, rst_o);
            check_value("idle load_o", 0, load_o);
            check_value("idle ready_o", 0, ready_o);
            check_value("idle start_op_o", 0, start_op_o);
            check_value("idle rd_weight_ld_o", 0, rd_weight_ld_o);
            check_value("idle rd_feature_ld_o", 0, rd_feature_ld_o);
            check_value("idle rd_rom_signals_ld_o", 0, rd_rom_signals_ld_o);
            check_value("idle done_o", 0, done_o);
        end
        for (int c = 0; c < N_CASES; c++) begin
            @(posedge clk_i);
            cur_case           <= c;
            filter_size_i      <= COL_W'(fs_tab[c]);
            total_channels_i   <= CNT_W'(ch_tab[c]);
            filter_rounds_i    <= CNT_W'(fr_tab[c]);
            input_rounds_i     <= CNT_W'(ir_tab[c]);
            inputs_per_round_i <= CNT_W'(ipr_tab[c]);
            case_seed          <= seed_tab[c];
            pass_cnt = 0;
            done_cnt = 0;
            @(posedge clk_i);
            layer_start_i <= 1'b1;
            @(posedge clk_i);
            layer_start_i <= 1'b0;
            // First layer starts before the weights are ready
            if (c == 0) begin
                repeat (6) begin
                    @(negedge clk_i);
                    check_value("load_o while weights not ready", 0, load_o);
                end
                @(posedge clk_i);
                hold_weight <= 1'b0;
            end
            while (done_cnt == 0) @(posedge clk_i);
            repeat (5) @(posedge clk_i);
            check_value("done_o pulses", 1, done_cnt);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* sa_ctrl.f */
rtl/sa_ctrl_pkg.sv
rtl/sa_pass_fsm.sv
rtl/sa_round_tracker.sv
rtl/sa_row_ctrl_decode.sv
rtl/sa_ctrl_top.sv
bench/sa_ctrl_tb.sv

/* Makefile */
# Verilator simulation of the systolic array sequencing controller

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module sa_ctrl_tb \
		-f sa_ctrl.f --Mdir obj_dir -o sa_ctrl_sim
	./obj_dir/sa_ctrl_sim | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
